// File: common/ts_monitor_config.svh
`ifndef TS_MONITOR_CONFIG_SVH
`define TS_MONITOR_CONFIG_SVH

// Register and buffer word width.
`define TS_DATA_WIDTH 32

// One transport stream packet.
`define TS_PACKET_BYTES 188
`define TS_PACKET_WORDS 47

// Header sync byte.
`define TS_SYNC_BYTE 8'h47

// PID filter table.
`define TS_PID_SLOTS 4
`define TS_PID_WIDTH 13

`endif

// File: common/ts_monitor_pkg.sv
`default_nettype none

`include "ts_monitor_config.svh"

package ts_monitor_pkg;

	// Field view of a PID slot register, enable at bit 16.
	typedef struct packed {
		logic [14:0]                pad_hi;
		logic                       enable;
		logic [2:0]                 pad_lo;
		logic [`TS_PID_WIDTH-1:0]   pid;
	} pid_entry_t;

	// Register word, seen either raw or as slot fields.
	typedef union packed {
		logic [`TS_DATA_WIDTH-1:0]  raw;
		pid_entry_t                 entry;
	} pid_reg_u;

	// Delayed stream byte towards capture.
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} ts_byte_t;

	// Header found in the stream with its PID.
	typedef struct packed {
		logic                       strobe;
		logic [`TS_PID_WIDTH-1:0]   pid;
	} ts_hdr_t;

endpackage

`default_nettype wire

// File: hdl/ts_byte_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_config.svh"

module ts_byte_pipe (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire [7:0]                 mpeg_data,
	input  wire                       mpeg_valid,
	input  wire                       mpeg_sync,
	output ts_monitor_pkg::ts_hdr_t   hdr,
	output ts_monitor_pkg::ts_byte_t  byte_out
);

	logic [7:0] data_d1;
	logic [7:0] data_d2;
	logic [7:0] data_d3;
	logic       sync_d1;
	logic       sync_d2;

	// Sync flags follow the data, only valid beats advance the line.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_d1 <= 1'b0;
			sync_d2 <= 1'b0;
		end else if (mpeg_valid) begin
			sync_d1 <= mpeg_sync;
			sync_d2 <= sync_d1;
		end
	end

	always_ff @(posedge clk) begin
		if (mpeg_valid) begin
			data_d1 <= mpeg_data;
			data_d2 <= data_d1;
			data_d3 <= data_d2;
		end
	end

	// Third header byte at the input, sync byte two beats back.
	assign hdr.strobe = mpeg_valid && sync_d2 && (data_d2 == `TS_SYNC_BYTE);
	assign hdr.pid    = {data_d1[4:0], mpeg_data}; // PID spans bytes 1 and 2.

	assign byte_out.valid = mpeg_valid;
	assign byte_out.data  = data_d3;

endmodule

`default_nettype wire

// File: hdl/pid_filter_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_config.svh"

module pid_filter_table (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire                             pid_write,
	input  wire [`TS_DATA_WIDTH-1:0]        pid_index,
	input  wire ts_monitor_pkg::pid_reg_u   pid_word,
	input  wire [`TS_DATA_WIDTH-1:0]        pid_read_index,
	output ts_monitor_pkg::pid_reg_u        pid_read_word,
	input  wire ts_monitor_pkg::ts_hdr_t    hdr,
	output logic                            hit
);

	localparam int SLOT_W = $clog2(`TS_PID_SLOTS);

	logic [`TS_PID_WIDTH-1:0] slot_pid [`TS_PID_SLOTS];
	logic                     slot_en  [`TS_PID_SLOTS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `TS_PID_SLOTS; i++) begin
				slot_pid[i] <= '0;
				slot_en[i]  <= 1'b0;
			end
		end else if (pid_write && (pid_index < `TS_PID_SLOTS)) begin
			slot_pid[pid_index[SLOT_W-1:0]] <= pid_word.entry.pid;
			slot_en[pid_index[SLOT_W-1:0]]  <= pid_word.entry.enable;
		end
	end

	// Pads read as zero, so does a slot that does not exist.
	always_comb begin
		pid_read_word = '0;
		if (pid_read_index < `TS_PID_SLOTS) begin
			pid_read_word.entry.enable = slot_en[pid_read_index[SLOT_W-1:0]];
			pid_read_word.entry.pid    = slot_pid[pid_read_index[SLOT_W-1:0]];
		end
	end

	always_comb begin
		hit = 1'b0;
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			if (hdr.strobe && slot_en[i] && (slot_pid[i] == hdr.pid))
				hit = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: ts_capture/ts_packet_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_config.svh"

module ts_packet_capture (
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire ts_monitor_pkg::ts_byte_t       byte_out,
	input  wire                                 hdr_strobe,
	input  wire                                 hit,
	input  wire                                 match_enable,
	input  wire                                 reading,
	input  wire [$clog2(`TS_PACKET_WORDS)-1:0]  buf_rd_addr,
	output logic [`TS_DATA_WIDTH-1:0]           buf_rd_data,
	output logic                                packet_complete,
	output logic [`TS_DATA_WIDTH-1:0]           matched_count
);

	localparam int LANES = `TS_DATA_WIDTH / 8;
	localparam int IDX_W = $clog2(`TS_PACKET_BYTES + 1);

	// Four byte lanes per word, byte 0 in the lowest lane.
	logic [LANES-1:0][7:0] pkt_buf [`TS_PACKET_WORDS];

	logic [IDX_W-1:0] byte_idx; // Parked at the packet size when idle.
	logic             start;
	logic             store;

	assign start = hdr_strobe && hit && match_enable && !reading;
	assign store = byte_out.valid && (byte_idx < `TS_PACKET_BYTES);

	always_ff @(posedge clk) begin
		if (store)
			pkt_buf[byte_idx / LANES][byte_idx % LANES] <= byte_out.data;
	end

	// The last byte of one packet can land in the header beat of the next.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			byte_idx        <= IDX_W'(`TS_PACKET_BYTES);
			packet_complete <= 1'b0;
			matched_count   <= '0;
		end else begin
			if (store) begin
				byte_idx <= byte_idx + 1'b1;
				if (byte_idx == `TS_PACKET_BYTES - 1)
					packet_complete <= 1'b1;
			end
			if (start) begin
				byte_idx        <= '0;
				packet_complete <= 1'b0;
				matched_count   <= matched_count + 1'b1;
			end
		end
	end

	always_comb begin
		if (buf_rd_addr < `TS_PACKET_WORDS)
			buf_rd_data = pkt_buf[buf_rd_addr];
		else
			buf_rd_data = '0;
	end

endmodule

`default_nettype wire

// File: ts_capture/ts_packet_readout.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_config.svh"

module ts_packet_readout (
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire                                 pump_request,
	input  wire                                 packet_complete,
	input  wire [`TS_DATA_WIDTH-1:0]            buf_rd_data,
	output logic [$clog2(`TS_PACKET_WORDS)-1:0] buf_rd_addr,
	output logic                                reading,
	output logic [`TS_DATA_WIDTH-1:0]           out_data,
	output logic [`TS_DATA_WIDTH-1:0]           out_index,
	output logic                                out_valid,
	output logic                                pump_ready
);

	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_WAIT   = 2'd1;
	localparam logic [1:0] ST_STREAM = 2'd2;

	logic [1:0] state;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= ST_IDLE;
			buf_rd_addr <= '0;
			reading     <= 1'b0;
			out_valid   <= 1'b0;
			pump_ready  <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (pump_request) begin
						pump_ready  <= 1'b0;
						reading     <= 1'b1; // Holds off new captures.
						buf_rd_addr <= '0;
						state       <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (packet_complete)
						state <= ST_STREAM;
				end
				ST_STREAM: begin
					if (buf_rd_addr < `TS_PACKET_WORDS) begin
						out_valid   <= 1'b1;
						buf_rd_addr <= buf_rd_addr + 1'b1;
					end else begin
						// One cycle past the last word.
						pump_ready <= 1'b1;
						reading    <= 1'b0;
						state      <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Word and index registered one cycle behind their address.
	always_ff @(posedge clk) begin
		if ((state == ST_STREAM) && (buf_rd_addr < `TS_PACKET_WORDS)) begin
			out_data  <= buf_rd_data;
			out_index <= `TS_DATA_WIDTH'(buf_rd_addr);
		end
	end

endmodule

`default_nettype wire

// File: hdl/ts_monitor_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_config.svh"

module ts_monitor_top (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire [7:0]                       mpeg_data,
	input  wire                             mpeg_valid,
	input  wire                             mpeg_sync,
	input  wire                             match_enable,
	input  wire                             pid_write,
	input  wire [`TS_DATA_WIDTH-1:0]        pid_index,
	input  wire ts_monitor_pkg::pid_reg_u   pid_word,
	input  wire [`TS_DATA_WIDTH-1:0]        pid_read_index,
	output ts_monitor_pkg::pid_reg_u        pid_read_word,
	input  wire                             pump_request,
	output logic                            pump_ready,
	output logic [`TS_DATA_WIDTH-1:0]       out_data,
	output logic [`TS_DATA_WIDTH-1:0]       out_index,
	output logic                            out_valid,
	output logic [`TS_DATA_WIDTH-1:0]       matched_count
);

	ts_monitor_pkg::ts_hdr_t             hdr;
	ts_monitor_pkg::ts_byte_t            byte_out;
	logic                                hit;
	logic                                packet_complete;
	logic                                reading;
	logic [$clog2(`TS_PACKET_WORDS)-1:0] buf_rd_addr;
	logic [`TS_DATA_WIDTH-1:0]           buf_rd_data;

	ts_byte_pipe ts_byte_pipe_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.mpeg_data  (mpeg_data),
		.mpeg_valid (mpeg_valid),
		.mpeg_sync  (mpeg_sync),
		.hdr        (hdr),
		.byte_out   (byte_out)
	);

	pid_filter_table pid_filter_table_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.pid_write      (pid_write),
		.pid_index      (pid_index),
		.pid_word       (pid_word),
		.pid_read_index (pid_read_index),
		.pid_read_word  (pid_read_word),
		.hdr            (hdr),
		.hit            (hit)
	);

	ts_packet_capture ts_packet_capture_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.byte_out        (byte_out),
		.hdr_strobe      (hdr.strobe),
		.hit             (hit),
		.match_enable    (match_enable),
		.reading         (reading),
		.buf_rd_addr     (buf_rd_addr),
		.buf_rd_data     (buf_rd_data),
		.packet_complete (packet_complete),
		.matched_count   (matched_count)
	);

	ts_packet_readout ts_packet_readout_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.pump_request    (pump_request),
		.packet_complete (packet_complete),
		.buf_rd_data     (buf_rd_data),
		.buf_rd_addr     (buf_rd_addr),
		.reading         (reading),
		.out_data        (out_data),
		.out_index       (out_index),
		.out_valid       (out_valid),
		.pump_ready      (pump_ready)
	);

endmodule

`default_nettype wire

// File: test/tb_ts_monitor_tasks.svh
`ifndef TB_TS_MONITOR_TASKS_SVH
`define TB_TS_MONITOR_TASKS_SVH

// Register view of a slot: PID in the low bits, enable at bit 16.
function automatic logic [31:0] expected_reg(input int idx);
	if (idx >= `TS_PID_SLOTS)
		return 32'h0;
	return (32'(exp_en[idx]) << 16) | 32'(exp_pid[idx]);
endfunction

function automatic bit pid_listed(input logic [`TS_PID_WIDTH-1:0] pid);
	bit found;
	found = 1'b0;
	for (int i = 0; i < `TS_PID_SLOTS; i++)
		if (exp_en[i] && (exp_pid[i] == pid))
			found = 1'b1;
	return found;
endfunction

// Pads carry random bits that must not stick.
task automatic write_pid(input int idx, input logic [`TS_PID_WIDTH-1:0] pid, input bit en);
	logic [31:0] raw;
	raw       = $random(seed);
	raw[16]   = en;
	raw[12:0] = pid;
	@(posedge clk);
	pid_write    <= 1'b1;
	pid_index    <= idx;
	pid_word.raw <= raw;
	@(posedge clk);
	pid_write <= 1'b0;
	if (idx < `TS_PID_SLOTS) begin
		exp_pid[idx] = pid;
		exp_en[idx]  = en;
	end
endtask

task automatic read_pid_check(input int idx);
	@(posedge clk);
	pid_read_index <= idx;
	@(negedge clk);
	assert (pid_read_word.raw == expected_reg(idx))
		else value_error("pid_read_word", expected_reg(idx), pid_read_word.raw);
endtask

task automatic send_byte(input logic [7:0] data, input bit sync, input bit gaps);
	while (gaps && (($random(seed) & 3) == 0)) begin
		@(posedge clk);
		mpeg_valid <= 1'b0;
		mpeg_sync  <= 1'b0;
	end
	@(posedge clk);
	mpeg_valid <= 1'b1;
	mpeg_data  <= data;
	mpeg_sync  <= sync;
endtask

task automatic send_packet(input logic [`TS_PID_WIDTH-1:0] pid, input bit with_sync,
		input bit gaps);
	logic [7:0] pkt [`TS_PACKET_BYTES];
	bit         will_match;
	int         r;
	r      = $random(seed);
	pkt[0] = `TS_SYNC_BYTE;
	pkt[1] = {r[7:5], pid[12:8]}; // Random flag bits above the PID.
	pkt[2] = pid[7:0];
	for (int i = 3; i < `TS_PACKET_BYTES; i++) begin
		r      = $random(seed);
		pkt[i] = r[7:0];
	end
	for (int i = 0; i < `TS_PACKET_BYTES; i++)
		send_byte(pkt[i], with_sync && (i == 0), gaps);
	repeat (3)
		send_byte(8'h00, 1'b0, 1'b0); // Push the tail through the pipe.
	// Match enable is steady for the whole packet.
	will_match = with_sync && match_enable && pid_listed(pid) && !hold_off;
	if (will_match) begin
		exp_count = exp_count + 1;
		for (int k = 0; k < `TS_PACKET_WORDS; k++)
			exp_words[k] = {pkt[4*k+3], pkt[4*k+2], pkt[4*k+1], pkt[4*k]};
	end
	@(posedge clk);
	mpeg_valid <= 1'b0;
	mpeg_sync  <= 1'b0;
	@(negedge clk);
	assert (matched_count == exp_count)
		else value_error("matched_count", exp_count, matched_count);
endtask

task automatic run_readout;
	int waited;
	@(posedge clk);
	pump_request <= 1'b1;
	@(posedge clk);
	pump_request <= 1'b0;
	waited = 0;
	@(negedge clk);
	while (!pump_ready) begin
		if (waited > READOUT_LIMIT)
			fail_now("pump_ready did not return after a readout request");
		@(negedge clk);
		waited++;
	end
	assert (word_count == `TS_PACKET_WORDS)
		else value_error("out_valid words", `TS_PACKET_WORDS, word_count);
endtask

`endif

// File: test/tb_ts_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_config.svh"

module tb_ts_monitor;

	localparam int NUM_PACKETS     = 8;
	localparam int NUM_READOUTS    = 5;
	localparam int PACKET_CYCLES   = 2 * `TS_PACKET_BYTES; // Random gaps and flush beats.
	localparam int READOUT_CYCLES  = `TS_PACKET_WORDS + 8;
	localparam int READOUT_LIMIT   = 4 * `TS_PACKET_BYTES;
	localparam int WATCHDOG_CYCLES =
		2 * (NUM_PACKETS * PACKET_CYCLES + NUM_READOUTS * READOUT_CYCLES) + 200;

	logic                           clk;
	logic                           rst_n;
	logic [7:0]                     mpeg_data;
	logic                           mpeg_valid;
	logic                           mpeg_sync;
	logic                           match_enable;
	logic                           pid_write;
	logic [`TS_DATA_WIDTH-1:0]      pid_index;
	ts_monitor_pkg::pid_reg_u       pid_word;
	logic [`TS_DATA_WIDTH-1:0]      pid_read_index;
	ts_monitor_pkg::pid_reg_u       pid_read_word;
	logic                           pump_request;
	logic                           pump_ready;
	logic [`TS_DATA_WIDTH-1:0]      out_data;
	logic [`TS_DATA_WIDTH-1:0]      out_index;
	logic                           out_valid;
	logic [`TS_DATA_WIDTH-1:0]      matched_count;

	// Scoreboard.
	integer                         seed = 5;
	logic [`TS_PID_WIDTH-1:0]       exp_pid [`TS_PID_SLOTS];
	logic                           exp_en  [`TS_PID_SLOTS];
	logic [`TS_DATA_WIDTH-1:0]      exp_words [`TS_PACKET_WORDS];
	logic [`TS_DATA_WIDTH-1:0]      exp_count;
	int                             word_count;
	bit                             hold_off; // A readout owns the buffer.

	ts_monitor_top ts_monitor_top_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.mpeg_data      (mpeg_data),
		.mpeg_valid     (mpeg_valid),
		.mpeg_sync      (mpeg_sync),
		.match_enable   (match_enable),
		.pid_write      (pid_write),
		.pid_index      (pid_index),
		.pid_word       (pid_word),
		.pid_read_index (pid_read_index),
		.pid_read_word  (pid_read_word),
		.pump_request   (pump_request),
		.pump_ready     (pump_ready),
		.out_data       (out_data),
		.out_index      (out_index),
		.out_valid      (out_valid),
		.matched_count  (matched_count)
	);

	task automatic value_error(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("ERROR: time %0t, %s expected %h, got %h", $time, name, expected, actual);
		$display("Test failures found");
		$fatal(1, "Stopped at the first mismatch.");
	endtask

	task automatic fail_now(input string why);
		$display("Failure at time %0t: %s", $time, why);
		$display("Test failures found");
		$fatal(1, "Stopped at the first failure.");
	endtask

	`include "tb_ts_monitor_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Counts readout words, restarted by each request.
	always @(posedge clk) begin
		if (pump_request)
			word_count <= 0;
		else if (out_valid)
			word_count <= word_count + 1;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
			out_valid |-> (out_index == word_count))
		else value_error("out_index", $sampled(word_count), $sampled(out_index));

	assert property (@(posedge clk) disable iff (!rst_n)
			out_valid |-> (out_data == exp_words[out_index[5:0]]))
		else value_error("out_data", exp_words[$sampled(out_index[5:0])], $sampled(out_data));

	assert property (@(posedge clk) disable iff (!rst_n)
			(out_valid && (out_index == 0)) |-> (out_data[7:0] == `TS_SYNC_BYTE))
		else value_error("out_data[7:0]", `TS_SYNC_BYTE, $sampled(out_data[7:0]));

	assert property (@(posedge clk) disable iff (!rst_n)
			out_valid |-> !pump_ready)
		else value_error("pump_ready", 0, $sampled(pump_ready));

	assert property (@(posedge clk) disable iff (!rst_n)
			$fell(out_valid) |-> pump_ready)
		else value_error("pump_ready", 1, $sampled(pump_ready));

	assert property (@(posedge clk) disable iff (!rst_n)
			pump_request |=> !pump_ready)
		else value_error("pump_ready", 0, $sampled(pump_ready));

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired, the test sequence did not finish in time.");
		$display("Test failures found");
		$fatal(1, "Watchdog timeout.");
	end

	initial begin
		rst_n          = 1'b0;
		mpeg_data      = '0;
		mpeg_valid     = 1'b0;
		mpeg_sync      = 1'b0;
		match_enable   = 1'b0;
		pid_write      = 1'b0;
		pid_index      = '0;
		pid_word       = '0;
		pid_read_index = '0;
		pump_request   = 1'b0;
		exp_count      = '0;
		hold_off       = 1'b0;
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			exp_pid[i] = '0;
			exp_en[i]  = 1'b0;
		end

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (pump_ready == 1'b0) else value_error("pump_ready", 0, pump_ready);
		assert (out_valid == 1'b0) else value_error("out_valid", 0, out_valid);
		assert (matched_count == 0) else value_error("matched_count", 0, matched_count);
		for (int i = 0; i <= `TS_PID_SLOTS; i++)
			read_pid_check(i);

		write_pid(0, 13'h0100, 1'b1);
		write_pid(1, 13'h1abc, 1'b1);
		write_pid(2, 13'h0200, 1'b0);
		write_pid(3, 13'h1fff, 1'b1);
		write_pid(4, 13'h0aaa, 1'b1); // Beyond the table, dropped.
		write_pid(9, 13'h0555, 1'b1);
		for (int i = 0; i <= `TS_PID_SLOTS; i++)
			read_pid_check(i);

		@(posedge clk);
		match_enable <= 1'b1;
		send_packet(13'h0100, 1'b1, 1'b1);
		run_readout();
		send_packet(13'h0555, 1'b1, 1'b1); // Not in the table.
		send_packet(13'h0200, 1'b1, 1'b1); // Slot disabled.
		@(posedge clk);
		match_enable <= 1'b0;
		send_packet(13'h1abc, 1'b1, 1'b1);
		@(posedge clk);
		match_enable <= 1'b1;
		send_packet(13'h1abc, 1'b0, 1'b1); // No sync strobe.
		send_packet(13'h1abc, 1'b1, 1'b1);
		run_readout();

		// Matching header while the buffer is streamed out.
		hold_off = 1'b1;
		fork
			run_readout();
			begin
				@(negedge clk);
				while (pump_ready)
					@(negedge clk);
				send_packet(13'h0100, 1'b1, 1'b0);
			end
		join
		hold_off = 1'b0;
		run_readout();

		write_pid(2, 13'h0200, 1'b1);
		read_pid_check(2);
		send_packet(13'h0200, 1'b1, 1'b1);
		run_readout();

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
+incdir+test
common/ts_monitor_pkg.sv
hdl/ts_byte_pipe.sv
hdl/pid_filter_table.sv
ts_capture/ts_packet_capture.sv
ts_capture/ts_packet_readout.sv
hdl/ts_monitor_top.sv
test/tb_ts_monitor.sv

// File: Bender.yml
package:
  name: ts_monitor

sources:
  - include_dirs:
      - common
    files:
      - common/ts_monitor_pkg.sv
      - hdl/ts_byte_pipe.sv
      - hdl/pid_filter_table.sv
      - ts_capture/ts_packet_capture.sv
      - ts_capture/ts_packet_readout.sv
      - hdl/ts_monitor_top.sv
  - target: test
    include_dirs:
      - common
      - test
    files:
      - test/tb_ts_monitor.sv
